// ==== verilog.f ====
exc_pkg.sv
exception_ctrl.sv
cp0_regs.sv
fetch_pc.sv
exc_unit_top.sv
exc_checker.sv
tb_exc_unit.sv

// ==== Bender.yml ====
package:
  name: exc_unit

sources:
  - exc_pkg.sv
  - exception_ctrl.sv
  - cp0_regs.sv
  - fetch_pc.sv
  - exc_unit_top.sv
  - target: test
    files:
      - exc_checker.sv
      - tb_exc_unit.sv

// ==== tb_exc_unit.sv ====
`timescale 1ns/1ps

module tb_exc_unit
    import exc_pkg::*;
();

    localparam int num_beats      = 2000;
    localparam int reset_cycles   = 10;
    localparam int timeout_cycles = num_beats + reset_cycles + 100;

    logic        clk;
    logic        arst_n;
    retire_t     retire;
    cp0_wr_t     cp0_wr;
    logic        flush;
    logic [31:0] pc;
    logic        status_exl;
    exccode_e    cause_exccode;
    logic        cause_bd;
    logic [31:0] epc;
    logic [31:0] badvaddr;
    logic [31:0] entryhi;
    int          errors;
    int          seed;
    int          cycles;

    exc_unit_top uut (
        .clk(clk), .arst_n(arst_n), .retire(retire), .cp0_wr(cp0_wr), .flush(flush),
        .pc(pc), .status_exl(status_exl), .cause_exccode(cause_exccode),
        .cause_bd(cause_bd), .epc(epc), .badvaddr(badvaddr), .entryhi(entryhi)
    );

    exc_checker u_checker (
        .clk(clk), .arst_n(arst_n), .retire(retire), .cp0_wr(cp0_wr), .flush(flush),
        .pc(pc), .status_exl(status_exl), .cause_exccode(cause_exccode),
        .cause_bd(cause_bd), .epc(epc), .badvaddr(badvaddr), .entryhi(entryhi),
        .errors(errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // one random retire beat and software write are driven right after the edge.
    task automatic drive_beat();
        retire_t     beat;
        cp0_wr_t     wr;
        logic [15:0] kinds;
        int          roll;
        beat               = '0;
        wr                 = '0;
        beat.valid         = ($unsigned($random(seed)) % 100) < 70;
        beat.refetch       = ($unsigned($random(seed)) % 100) < 5;
        beat.pc            = $random(seed) & 32'hffff_fffc;
        beat.badvaddr      = $random(seed);
        beat.in_delay_slot = $random(seed) & 1;
        roll = $unsigned($random(seed)) % 100;
        if (roll < 55) kinds = 16'd1 << ($unsigned($random(seed)) % 16);
        else if (roll < 70) kinds = $random(seed);
        else kinds = '0;
        beat.flags = {kinds, |kinds[15:5]};     // has_exp covers the non tlb data kinds.
        wr.valid = ($unsigned($random(seed)) % 100) < 15;
        roll = $unsigned($random(seed)) % 3;
        wr.regnum = (roll == 0) ? cp0_status : (roll == 1) ? cp0_epc : cp0_reg_e'(5'd9);
        wr.data = $random(seed);
        // an eret never retires together with a status write.
        if (kinds[15] && wr.regnum == cp0_status) wr.regnum = cp0_epc;
        retire <= beat;
        cp0_wr <= wr;
    endtask

    initial begin
        seed   = 86152;
        arst_n = 1'b0;
        retire = '0;
        cp0_wr = '0;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
        repeat (num_beats) begin
            @(posedge clk);
            drive_beat();
        end
        @(posedge clk);
        retire <= '0;
        cp0_wr <= '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: stimulus did not finish");
        $display("test failed");
        $finish;
    end

endmodule

// ==== exc_checker.sv ====
`timescale 1ns/1ps

module exc_checker
    import exc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  retire_t     retire,
    input  cp0_wr_t     cp0_wr,
    input  logic        flush,
    input  logic [31:0] pc,
    input  logic        status_exl,
    input  exccode_e    cause_exccode,
    input  logic        cause_bd,
    input  logic [31:0] epc,
    input  logic [31:0] badvaddr,
    input  logic [31:0] entryhi,
    output int          errors
);

    int          err_count = 0;
    logic [31:0] m_pc;
    logic [31:0] m_epc;
    logic [31:0] m_badvaddr;
    logic [31:0] m_entryhi;
    logic        m_exl;
    logic        m_bd;
    logic [4:0]  m_code;

    assign errors = err_count;

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("error %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // returns the index of the winning kind in priority order and 16 when no kind is set.
    function automatic int winner(input exc_flags_t f);
        logic [15:0] order;
        int i;
        order = {f.intr, f.i_refill_tlbl, f.i_invalid_tlbl, f.inst_adel, f.ri, f.overflow,
                 f.syscall, f.brk, f.eret, f.d_refill_tlbl, f.d_invalid_tlbl,
                 f.d_refill_tlbs, f.d_invalid_tlbs, f.data_adel, f.data_ades, f.modify};
        winner = 16;
        for (i = 0; i < 16; i++) begin
            if (order[15 - i] && winner == 16) winner = i;
        end
    endfunction

    // outputs are compared against the state before this edge and then the model steps.
    always @(posedge clk or negedge arst_n) begin : model_step
        exc_flags_t f;
        int         k;
        logic       exc;
        logic       entry;
        logic       ret;
        logic       cap_inst;
        logic       cap_bva;
        logic       cap_ehi;
        logic [31:0] addr;
        logic [4:0] code;
        f = retire.flags;
        if (!arst_n) begin
            m_pc       = boot_vector;
            m_exl      = 1'b1;
            m_code     = 5'd0;
            m_bd       = 1'b0;
            m_epc      = 32'd0;
            m_badvaddr = 32'd0;
            m_entryhi  = 32'd0;
        end else begin
            compare_field("pc", pc, m_pc);
            compare_field("status_exl", status_exl, m_exl);
            compare_field("cause_exccode", cause_exccode, m_code);
            compare_field("cause_bd", cause_bd, m_bd);
            compare_field("epc", epc, m_epc);
            compare_field("badvaddr", badvaddr, m_badvaddr);
            compare_field("entryhi", entryhi, m_entryhi);
            exc = retire.valid && !retire.refetch && (f.has_exp || f.d_refill_tlbl ||
                  f.d_invalid_tlbl || f.d_refill_tlbs || f.d_invalid_tlbs || f.modify);
            compare_field("flush", flush, retire.valid && (retire.refetch || exc));
            k     = winner(f);
            ret   = exc && (k == 8);
            entry = exc && (k != 8);
            case (k)
                1, 2, 9, 10: code = 5'd2;
                3, 13:       code = 5'd4;
                4:           code = 5'd10;
                5:           code = 5'd12;
                6:           code = 5'd8;
                7:           code = 5'd9;
                11, 12:      code = 5'd3;
                14:          code = 5'd5;
                15:          code = 5'd1;
                default:     code = 5'd0;   // interrupt or nothing selected.
            endcase
            cap_inst = (k >= 1 && k <= 3);
            cap_bva  = cap_inst || (k >= 9 && k <= 15);
            cap_ehi  = cap_bva && k != 3 && k != 13 && k != 14;
            addr     = cap_inst ? retire.pc : retire.badvaddr;
            if (retire.valid && retire.refetch) begin
                m_pc = retire.pc;
            end else if (ret) begin
                m_pc  = m_epc;              // return target is the epc before this edge.
                m_exl = 1'b0;
            end else if (entry) begin
                m_pc   = (k == 1 || k == 9 || k == 11) ? refill_vector : general_vector;
                m_exl  = 1'b1;
                m_code = code;
                m_bd   = retire.in_delay_slot;
                m_epc  = retire.in_delay_slot ? retire.pc - 32'd4 : retire.pc;
                if (cap_bva) m_badvaddr = addr;
                if (cap_ehi) m_entryhi[31:13] = addr[31:13];
            end else if (retire.valid) begin
                m_pc = m_pc + 32'd4;
            end
            if (!entry && cp0_wr.valid) begin
                if (cp0_wr.regnum == cp0_status && !ret) m_exl = cp0_wr.data[1];
                if (cp0_wr.regnum == cp0_epc) m_epc = cp0_wr.data;
            end
        end
    end

endmodule

// ==== exc_unit_top.sv ====
`timescale 1ns/1ps

module exc_unit_top
    import exc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  retire_t     retire,
    input  cp0_wr_t     cp0_wr,
    output logic        flush,
    output logic [31:0] pc,
    output logic        status_exl,
    output exccode_e    cause_exccode,
    output logic        cause_bd,
    output logic [31:0] epc,
    output logic [31:0] badvaddr,
    output logic [31:0] entryhi
);

    cp0_upd_t    upd;
    logic        redirect_ena;
    logic [31:0] redirect_pc;

    exception_ctrl u_exception_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .retire       (retire),
        .epc          (epc),
        .upd          (upd),
        .flush        (flush),
        .redirect_ena (redirect_ena),
        .redirect_pc  (redirect_pc)
    );

    cp0_regs u_cp0_regs (
        .clk           (clk),
        .arst_n        (arst_n),
        .upd           (upd),
        .cp0_wr        (cp0_wr),
        .status_exl    (status_exl),
        .cause_exccode (cause_exccode),
        .cause_bd      (cause_bd),
        .epc           (epc),
        .badvaddr      (badvaddr),
        .entryhi       (entryhi)
    );

    fetch_pc u_fetch_pc (
        .clk          (clk),
        .arst_n       (arst_n),
        .retire_valid (retire.valid),
        .redirect_ena (redirect_ena),
        .redirect_pc  (redirect_pc),
        .pc           (pc)
    );

endmodule

// ==== fetch_pc.sv ====
`timescale 1ns/1ps

module fetch_pc
    import exc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        retire_valid,
    input  logic        redirect_ena,
    input  logic [31:0] redirect_pc,
    output logic [31:0] pc
);

    logic [31:0] pc_next;

    assign pc_next = redirect_ena ? redirect_pc : pc + 32'd4;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= boot_vector;
        end else if (retire_valid) begin
            pc <= pc_next;      // pc only moves when an instruction retires.
        end
    end

    // the controller only redirects on a retiring instruction.
    a_redirect_needs_retire: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(redirect_ena) |-> retire_valid);

endmodule

// ==== cp0_regs.sv ====
`timescale 1ns/1ps

module cp0_regs
    import exc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  cp0_upd_t    upd,
    input  cp0_wr_t     cp0_wr,
    output logic        status_exl,
    output exccode_e    cause_exccode,
    output logic        cause_bd,
    output logic [31:0] epc,
    output logic [31:0] badvaddr,
    output logic [31:0] entryhi
);

    logic sw_status;
    logic sw_epc;

    assign sw_status = cp0_wr.valid && (cp0_wr.regnum == cp0_status);
    assign sw_epc    = cp0_wr.valid && (cp0_wr.regnum == cp0_epc);

    // status EXL comes up set because the core boots in kernel mode.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            status_exl <= 1'b1;
        end else if (upd.update_ena) begin
            status_exl <= 1'b1;
        end else if (upd.cls_exl) begin
            status_exl <= 1'b0;
        end else if (sw_status) begin
            status_exl <= cp0_wr.data[1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cause_exccode <= exc_int;
            cause_bd      <= 1'b0;
            epc           <= 32'd0;
        end else if (upd.update_ena) begin
            cause_exccode <= upd.exccode;
            cause_bd      <= upd.bd;
            epc           <= upd.epc;
        end else if (sw_epc) begin
            epc <= cp0_wr.data;     // software write loses to an exception entry.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            badvaddr <= 32'd0;
        end else if (upd.badvaddr_ena) begin
            badvaddr <= upd.badvaddr;
        end
    end

    // only the vpn2 field is written here.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entryhi <= 32'd0;
        end else if (upd.entryhi_ena) begin
            entryhi[31:13] <= upd.entryhi_vpn2;
        end
    end

    // an eret and a status write from the same instruction stream cannot retire together.
    a_cls_vs_sw_status: assert property (@(posedge clk) disable iff (!arst_n)
        !(upd.cls_exl && sw_status));

endmodule

// ==== exception_ctrl.sv ====
`timescale 1ns/1ps

module exception_ctrl
    import exc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  retire_t     retire,
    input  logic [31:0] epc,
    output cp0_upd_t    upd,
    output logic        flush,
    output logic        redirect_ena,
    output logic [31:0] redirect_pc
);

    exc_flags_t f;
    logic       do_refetch;
    logic       exc_present;
    logic       cap_bva;        // load badvaddr.
    logic       cap_ehi;        // load entryhi vpn2.
    logic       cap_inst;       // address comes from the pc and not from the data address.
    logic [31:0] cap_addr;

    assign f = retire.flags;

    assign do_refetch  = retire.valid & retire.refetch;
    assign exc_present = retire.valid & ~retire.refetch & (f.has_exp |
                         f.d_refill_tlbl | f.d_invalid_tlbl |
                         f.d_refill_tlbs | f.d_invalid_tlbs | f.modify);

    assign flush        = do_refetch | exc_present;
    assign redirect_ena = do_refetch | exc_present;

    always_comb begin
        upd         = '0;
        redirect_pc = general_vector;
        cap_bva     = 1'b0;
        cap_ehi     = 1'b0;
        cap_inst    = 1'b0;
        if (do_refetch) begin
            redirect_pc = retire.pc;   // replay the instruction and leave cp0 untouched.
        end else if (exc_present) begin
            upd.update_ena = 1'b1;
            upd.bd         = retire.in_delay_slot;
            upd.epc        = retire.in_delay_slot ? retire.pc - 32'd4 : retire.pc;
            if (f.intr) begin
                upd.exccode = exc_int;
            end else if (f.i_refill_tlbl) begin
                upd.exccode = exc_tlbl;
                redirect_pc = refill_vector;
                {cap_bva, cap_ehi, cap_inst} = 3'b111;
            end else if (f.i_invalid_tlbl) begin
                upd.exccode = exc_tlbl;
                {cap_bva, cap_ehi, cap_inst} = 3'b111;
            end else if (f.inst_adel) begin
                upd.exccode = exc_adel;
                {cap_bva, cap_inst} = 2'b11;
            end else if (f.ri) begin
                upd.exccode = exc_ri;
            end else if (f.overflow) begin
                upd.exccode = exc_ov;
            end else if (f.syscall) begin
                upd.exccode = exc_sys;
            end else if (f.brk) begin
                upd.exccode = exc_bp;
            end else if (f.eret) begin
                // return from exception only drops EXL.
                upd.update_ena = 1'b0;
                upd.cls_exl    = 1'b1;
                redirect_pc    = epc;
            end else if (f.d_refill_tlbl) begin
                upd.exccode = exc_tlbl;
                redirect_pc = refill_vector;
                {cap_bva, cap_ehi} = 2'b11;
            end else if (f.d_invalid_tlbl) begin
                upd.exccode = exc_tlbl;
                {cap_bva, cap_ehi} = 2'b11;
            end else if (f.d_refill_tlbs) begin
                upd.exccode = exc_tlbs;
                redirect_pc = refill_vector;
                {cap_bva, cap_ehi} = 2'b11;
            end else if (f.d_invalid_tlbs) begin
                upd.exccode = exc_tlbs;
                {cap_bva, cap_ehi} = 2'b11;
            end else if (f.data_adel) begin
                upd.exccode = exc_adel;
                cap_bva     = 1'b1;
            end else if (f.data_ades) begin
                upd.exccode = exc_ades;
                cap_bva     = 1'b1;
            end else if (f.modify) begin
                upd.exccode = exc_mod;
                {cap_bva, cap_ehi} = 2'b11;
            end
        end
        upd.badvaddr_ena = cap_bva;
        upd.badvaddr     = cap_addr;
        upd.entryhi_ena  = cap_ehi;
        upd.entryhi_vpn2 = cap_addr[31:13];
    end

    assign cap_addr = cap_inst ? retire.pc : retire.badvaddr;

    // an eret never looks like an exception entry to cp0.
    a_cls_vs_update: assert property (@(posedge clk) disable iff (!arst_n)
        !(upd.cls_exl && upd.update_ena));

    a_entryhi_badvaddr: assert property (@(posedge clk) disable iff (!arst_n)
        upd.entryhi_ena |-> upd.badvaddr_ena);

endmodule

// ==== exc_pkg.sv ====
package exc_pkg;

    // one bit per exception kind, as reported by the last pipeline stage.
    typedef struct packed {
        logic eret;
        logic syscall;
        logic brk;
        logic inst_adel;
        logic data_adel;
        logic data_ades;
        logic overflow;
        logic ri;
        logic intr;
        logic i_refill_tlbl;
        logic i_invalid_tlbl;
        logic d_refill_tlbl;
        logic d_invalid_tlbl;
        logic d_refill_tlbs;
        logic d_invalid_tlbs;
        logic modify;
        logic has_exp;          // summary of all kinds except the tlb data ones.
    } exc_flags_t;

    typedef struct packed {
        logic        valid;
        logic        refetch;
        logic [31:0] pc;
        logic [31:0] badvaddr;
        logic        in_delay_slot;
        exc_flags_t  flags;
    } retire_t;

    typedef enum logic [4:0] {
        exc_int  = 5'd0,
        exc_mod  = 5'd1,
        exc_tlbl = 5'd2,
        exc_tlbs = 5'd3,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_sys  = 5'd8,
        exc_bp   = 5'd9,
        exc_ri   = 5'd10,
        exc_ov   = 5'd12
    } exccode_e;

    // update record from the exception controller to coprocessor 0.
    typedef struct packed {
        logic        update_ena;
        exccode_e    exccode;
        logic        bd;
        logic [31:0] epc;
        logic        badvaddr_ena;
        logic [31:0] badvaddr;
        logic        entryhi_ena;
        logic [18:0] entryhi_vpn2;
        logic        cls_exl;
    } cp0_upd_t;

    // only these two registers accept software writes.
    typedef enum logic [4:0] {
        cp0_status = 5'd12,
        cp0_epc    = 5'd14
    } cp0_reg_e;

    typedef struct packed {
        logic        valid;
        cp0_reg_e    regnum;
        logic [31:0] data;
    } cp0_wr_t;

    localparam logic [31:0] boot_vector    = 32'hbfc0_0000;
    localparam logic [31:0] refill_vector  = 32'hbfc0_0200;
    localparam logic [31:0] general_vector = 32'hbfc0_0380;

endpackage
